// ==== list.f ====
+incdir+.
frontend_pkg.sv
fetch_queue_if.sv
next_pc_predictor.sv
fetch_stage.sv
dispatch_queue.sv
decode_stage.sv
frontend_top.sv
frontend_properties.sv
frontend_tb_clock.sv
frontend_tb.sv

// ==== frontend_tb.sv ====
/*
 * front end testbench: 512-byte combinational instruction memory, always valid
 * memory aliases above 0x1ff, unused slots hold addi x0, x0, <byte address>
 * fetch runs ahead freely, only the first packets of each test are compared
 */
`timescale 1ns/100ps

module frontend_tb;
	localparam logic [2:0] CLS_ALU    = frontend_pkg::ALU;
	localparam logic [2:0] CLS_LOAD   = frontend_pkg::LOAD;
	localparam logic [2:0] CLS_STORE  = frontend_pkg::STORE;
	localparam logic [2:0] CLS_BRANCH = frontend_pkg::BRANCH;
	localparam logic [2:0] CLS_JUMP   = frontend_pkg::JUMP;
	localparam logic [2:0] CLS_UPPER  = frontend_pkg::UPPER;

	// one expected dispatch, in dispatch order
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] inst;
		logic [4:0]  dest;
		logic [1:0]  req;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  op_class;
		logic        illegal;
		logic [31:0] npc_pred;
		logic        take;
	} entry_t;

	// entries from first up to the next test's first belong to this test
	typedef struct {
		string       name;
		int          first;
		logic [31:0] start_pc;
		bit          do_squash;
		bit          random_stall;
		int          train_n;
		bit          train_taken;
		logic [31:0] train_pc;
		logic [31:0] train_target;
	} test_t;

	logic             clock, reset;
	logic [63:0]      icache_data;
	logic             icache_valid;
	logic [31:0]      imem_addr;
	logic             squash;
	logic [31:0]      squash_pc;
	logic             update_valid, update_is_branch, update_taken;
	logic [31:0]      update_pc, update_target;
	logic             dispatch_stall, dispatch_valid;
	logic [31:0]      dispatch_pc, dispatch_npc, dispatch_npc_pred, dispatch_inst;
	logic [2:0]       dispatch_op_class;
	logic [4:0]       dispatch_dest_reg_idx;
	logic [1:0]       dispatch_req_reg;
	logic [1:0][4:0]  dispatch_input_reg_idx;
	logic             dispatch_rd_mem, dispatch_wr_mem, dispatch_illegal;
	logic             dispatch_cond_branch, dispatch_uncond_branch, dispatch_take_branch;

	logic [63:0]      imem [64];
	entry_t           table_q[$];
	test_t            tests[$];
	string            test_name = "reset";
	int               exp_idx = 0;
	int               exp_end = 0;
	int               error_count = 0;
	int               check_count = 0;
	int               cycle_count = 0;
	int               cycle_limit = 0;
	logic             hold_pending = 1'b0;
	logic [31:0]      held_pc, held_inst;

	frontend_tb_clock i_clock (.clock(clock), .reset(reset));
	frontend_top i_dut (.*);

	// same-cycle cache answer
	assign icache_data = imem[imem_addr[8:3]];

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic add_entry(input logic [31:0] addr, input logic [31:0] inst,
			input logic [4:0] dest, input logic [1:0] req, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [2:0] op_class, input logic illegal,
			input logic [31:0] npc_pred, input logic take);
		table_q.push_back('{addr, inst, dest, req, rs1, rs2, op_class, illegal, npc_pred, take});
	endtask

	task automatic add_test(input string name, input logic [31:0] start_pc,
			input bit do_squash, input bit random_stall, input int train_n,
			input bit train_taken, input logic [31:0] train_pc, input logic [31:0] train_target);
		tests.push_back('{name, table_q.size(), start_pc, do_squash, random_stall,
			train_n, train_taken, train_pc, train_target});
	endtask

	// addi x0, x0, <byte address>
	function automatic logic [31:0] filler_inst(input logic [31:0] addr);
		return {addr[11:0], 20'h00013};
	endfunction

	task automatic load_program();
		for (int i = 0; i < 64; i++) begin
			imem[i] = {filler_inst(i * 8 + 4), filler_inst(i * 8)};
		end
		foreach (table_q[k]) begin
			if (table_q[k].addr[2]) begin
				imem[table_q[k].addr[8:3]][63:32] = table_q[k].inst;
			end else begin
				imem[table_q[k].addr[8:3]][31:0] = table_q[k].inst;
			end
		end
	endtask

	task automatic compare_packet(input int idx);
		entry_t e;
		string  tag;
		e   = table_q[idx];
		tag = $sformatf("%s #%0d", test_name, idx);
		check_value({tag, " pc"}, e.addr, dispatch_pc);
		check_value({tag, " inst"}, e.inst, dispatch_inst);
		check_value({tag, " npc"}, e.addr + 32'd4, dispatch_npc);
		check_value({tag, " npc_pred"}, e.npc_pred, dispatch_npc_pred);
		check_value({tag, " take_branch"}, e.take, dispatch_take_branch);
		check_value({tag, " op_class"}, e.op_class, dispatch_op_class);
		check_value({tag, " dest_reg_idx"}, e.dest, dispatch_dest_reg_idx);
		check_value({tag, " req_reg"}, e.req, dispatch_req_reg);
		check_value({tag, " rs1 idx"}, e.rs1, dispatch_input_reg_idx[0]);
		check_value({tag, " rs2 idx"}, e.rs2, dispatch_input_reg_idx[1]);
		check_value({tag, " illegal"}, e.illegal, dispatch_illegal);
		// memory and branch flags follow the class
		check_value({tag, " rd_mem"}, e.op_class == CLS_LOAD, dispatch_rd_mem);
		check_value({tag, " wr_mem"}, e.op_class == CLS_STORE, dispatch_wr_mem);
		check_value({tag, " cond_branch"}, e.op_class == CLS_BRANCH, dispatch_cond_branch);
		check_value({tag, " uncond_branch"}, e.op_class == CLS_JUMP, dispatch_uncond_branch);
	endtask

	// one resolved-branch strobe per cycle
	task automatic apply_training(input test_t t);
		for (int n = 0; n < t.train_n; n++) begin
			update_valid     <= 1'b1;
			update_is_branch <= 1'b1;
			update_taken     <= t.train_taken;
			update_pc        <= t.train_pc;
			update_target    <= t.train_target;
			@(posedge clock);
		end
		update_valid <= 1'b0;
	endtask

	task automatic run_test(input test_t t, input int count);
		int errors_before;
		errors_before = error_count;
		if (t.do_squash) begin
			// stall first so the squash has a full queue to drop
			dispatch_stall <= 1'b1;
			repeat (8) @(posedge clock);
			squash    <= 1'b1;
			squash_pc <= t.start_pc;
			@(posedge clock);
			squash         <= 1'b0;
			dispatch_stall <= 1'b0;
		end
		test_name = t.name;
		exp_idx   = t.first;
		exp_end   = t.first + count;
		while (exp_idx < exp_end) begin
			@(posedge clock);
			if (t.random_stall) begin
				dispatch_stall <= ($urandom % 2) == 1;
			end
		end
		dispatch_stall <= 1'b0;
		$display("test %-12s %0d packets, %0d errors", t.name, count,
			error_count - errors_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// dispatch monitor and timeout
	//////////////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		// cache address is the pc word, low three bits clear
		if (!reset) begin
			check_value({test_name, " imem_addr low bits"}, 32'd0, imem_addr[2:0]);
		end
		// a stalled packet must still be there one edge later
		if (hold_pending) begin
			check_value({test_name, " hold valid"}, 1'b1, dispatch_valid);
			check_value({test_name, " hold pc"}, held_pc, dispatch_pc);
			check_value({test_name, " hold inst"}, held_inst, dispatch_inst);
		end
		// taken downstream at an edge with valid high and no stall
		if (!reset && !squash && dispatch_valid && !dispatch_stall && exp_idx < exp_end) begin
			compare_packet(exp_idx);
			exp_idx = exp_idx + 1;
		end
		hold_pending = !reset && !squash && dispatch_valid && dispatch_stall;
		held_pc      = dispatch_pc;
		held_inst    = dispatch_inst;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: expected packets not dispatched after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// program table and test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int          count;
		int          assert_failures;
		void'($urandom(32'heb4e));
		icache_valid     = 1'b1;
		squash           = 1'b0;
		squash_pc        = '0;
		update_valid     = 1'b0;
		update_is_branch = 1'b0;
		update_taken     = 1'b0;
		update_pc        = '0;
		update_target    = '0;
		dispatch_stall   = 1'b0;

		// test: name, start pc, squash, random stall, updates, taken, update pc, target
		// entry: addr, inst, dest, req_reg, rs1, rs2, op_class, illegal, npc_pred, take
		add_test("straight", 'h00, 0, 0, 0, 0, 'h0, 'h0);
		add_entry('h00, 'h123450b7, 1, 2'b00, 0, 0, CLS_UPPER, 0, 'h04, 0);
		add_entry('h04, 'h00001117, 2, 2'b00, 0, 0, CLS_UPPER, 0, 'h08, 0);
		add_entry('h08, 'h00508193, 3, 2'b01, 1, 0, CLS_ALU, 0, 'h0c, 0);
		add_entry('h0c, 'h00310233, 4, 2'b11, 2, 3, CLS_ALU, 0, 'h10, 0);
		add_entry('h10, 'h00822283, 5, 2'b01, 4, 0, CLS_LOAD, 0, 'h14, 0);
		add_entry('h14, 'h00522623, 0, 2'b11, 4, 5, CLS_STORE, 0, 'h18, 0);
		add_entry('h18, 'h00208463, 0, 2'b11, 1, 2, CLS_BRANCH, 0, 'h1c, 0);
		add_entry('h1c, 'h010000ef, 1, 2'b00, 0, 0, CLS_JUMP, 0, 'h20, 0);
		add_entry('h20, 'h0003837f, 0, 2'b01, 7, 0, CLS_ALU, 1, 'h24, 0);
		add_test("squash", 'h0c, 1, 0, 0, 0, 'h0, 'h0);
		add_entry('h0c, 'h00310233, 4, 2'b11, 2, 3, CLS_ALU, 0, 'h10, 0);
		add_entry('h10, 'h00822283, 5, 2'b01, 4, 0, CLS_LOAD, 0, 'h14, 0);
		add_entry('h14, 'h00522623, 0, 2'b11, 4, 5, CLS_STORE, 0, 'h18, 0);
		add_test("btb_taken", 'h38, 1, 0, 1, 1, 'h40, 'h60);
		add_entry('h38, 'h00148493, 9, 2'b01, 9, 0, CLS_ALU, 0, 'h3c, 0);
		add_entry('h3c, 'h00150513, 10, 2'b01, 10, 0, CLS_ALU, 0, 'h40, 0);
		add_entry('h40, 'h02208063, 0, 2'b11, 1, 2, CLS_BRANCH, 0, 'h60, 1);
		add_entry('h60, 'h00158593, 11, 2'b01, 11, 0, CLS_ALU, 0, 'h64, 0);
		add_entry('h64, 'h00160613, 12, 2'b01, 12, 0, CLS_ALU, 0, 'h68, 0);
		add_test("btb_cleared", 'h40, 1, 0, 2, 0, 'h40, 'h60);
		add_entry('h40, 'h02208063, 0, 2'b11, 1, 2, CLS_BRANCH, 0, 'h44, 0);
		add_entry('h44, 'h00168693, 13, 2'b01, 13, 0, CLS_ALU, 0, 'h48, 0);
		// jalr returns to the jal's pc+4 once, then falls through
		add_test("ras", 'h80, 1, 0, 0, 0, 'h0, 'h0);
		add_entry('h80, 'h020000ef, 1, 2'b00, 0, 0, CLS_JUMP, 0, 'h84, 0);
		add_entry('h84, 'h00138393, 7, 2'b01, 7, 0, CLS_ALU, 0, 'h88, 0);
		add_entry('h88, 'h00008067, 0, 2'b01, 1, 0, CLS_JUMP, 0, 'h84, 0);
		add_entry('h84, 'h00138393, 7, 2'b01, 7, 0, CLS_ALU, 0, 'h88, 0);
		add_entry('h88, 'h00008067, 0, 2'b01, 1, 0, CLS_JUMP, 0, 'h8c, 0);
		// addi x(i+1), x(i), i
		add_test("stall", 'ha0, 1, 1, 0, 0, 'h0, 'h0);
		for (int i = 0; i < 12; i++) begin
			add_entry('ha0 + 4 * i, (i << 20) | (i << 15) | ((i + 1) << 7) | 'h13,
				i + 1, 2'b01, i, 0, CLS_ALU, 0, 'ha4 + 4 * i, 0);
		end

		load_program();
		cycle_limit = 4 * table_q.size() + 200;

		@(posedge clock);
		while (reset) begin
			@(posedge clock);
		end
		foreach (tests[k]) begin
			if (k + 1 < tests.size()) begin
				count = tests[k + 1].first - tests[k].first;
			end else begin
				count = table_q.size() - tests[k].first;
			end
			apply_training(tests[k]);
			run_test(tests[k], count);
		end

		assert_failures = i_dut.i_queue.i_queue_props.failures
			+ i_dut.i_fetch.i_fetch_props.failures;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests.size(), check_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end
endmodule

// ==== frontend_tb_clock.sv ====
/*
 * testbench clock, 40 ns period, first rising edge at 20 ns
 * reset is high from time zero and drops after the 5th rising edge
 */
`timescale 1ns/100ps

module frontend_tb_clock (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// held for five rising edges
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
	end
endmodule

// ==== frontend_properties.sv ====
/*
 * protocol checks for the fetch queue and the squash redirect
 * bound twice: queue signals from dispatch_queue, pc from fetch_stage
 * each bind ties off the inputs its target does not own
 */
`timescale 1ns/100ps

module frontend_properties (
	input logic        clock,
	input logic        reset,
	input logic        write_en,
	input logic        full,
	input logic        read_en,
	input logic        empty,
	input logic        flush,
	input logic        squash,
	input logic [31:0] squash_pc,
	input logic [31:0] pc
);
	// read back by the testbench at the end of the run
	int failures = 0;

	write_while_full: assert property (@(posedge clock) disable iff (reset)
		!(write_en && full))
	else begin
		failures++;
		$error("queue written while full");
	end

	read_while_empty: assert property (@(posedge clock) disable iff (reset)
		!(read_en && empty))
	else begin
		failures++;
		$error("queue read while empty");
	end

	// flush drops every entry at once
	empty_after_flush: assert property (@(posedge clock) disable iff (reset)
		flush |=> empty)
	else begin
		failures++;
		$error("queue not empty after flush");
	end

	// redirect lands one edge after the squash
	pc_after_squash: assert property (@(posedge clock) disable iff (reset)
		squash |=> (pc == $past(squash_pc)))
	else begin
		failures++;
		$error("pc does not match squash_pc after squash");
	end
endmodule

bind dispatch_queue frontend_properties i_queue_props (
	.clock     (clock),
	.reset     (reset),
	.write_en  (fq.write_en),
	.full      (fq.full),
	.read_en   (fq.read_en),
	.empty     (fq.empty),
	.flush     (fq.flush),
	.squash    (1'b0),
	.squash_pc (32'd0),
	.pc        (32'd0)
);

bind fetch_stage frontend_properties i_fetch_props (
	.clock     (clock),
	.reset     (reset),
	.write_en  (1'b0),
	.full      (1'b0),
	.read_en   (1'b0),
	.empty     (1'b1),
	.flush     (1'b0),
	.squash    (squash),
	.squash_pc (squash_pc),
	.pc        (pc_reg)
);

// ==== frontend_top.sv ====
/*
 * front end top: fetch, fetch queue and decode
 * resolved-branch inputs are packed into one update for the predictor
 */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module frontend_top (
	input  logic               clock,
	input  logic               reset,
	// instruction cache
	input  logic [63:0]        icache_data,
	input  logic               icache_valid,
	output logic [`XLEN-1:0]   imem_addr,
	// redirect from the reorder buffer
	input  logic               squash,
	input  logic [`XLEN-1:0]   squash_pc,
	// branch resolution
	input  logic               update_valid,
	input  logic               update_is_branch,
	input  logic               update_taken,
	input  logic [`XLEN-1:0]   update_pc,
	input  logic [`XLEN-1:0]   update_target,
	// dispatch
	input  logic               dispatch_stall,
	output logic               dispatch_valid,
	output logic [`XLEN-1:0]   dispatch_pc,
	output logic [`XLEN-1:0]   dispatch_npc,
	output logic [`XLEN-1:0]   dispatch_npc_pred,
	output logic [31:0]        dispatch_inst,
	output logic [2:0]         dispatch_op_class,
	output logic [4:0]         dispatch_dest_reg_idx,
	output logic [1:0]         dispatch_req_reg,
	output logic [1:0][4:0]    dispatch_input_reg_idx,
	output logic               dispatch_rd_mem,
	output logic               dispatch_wr_mem,
	output logic               dispatch_cond_branch,
	output logic               dispatch_uncond_branch,
	output logic               dispatch_take_branch,
	output logic               dispatch_illegal
);
	frontend_pkg::branch_update_t   update;
	frontend_pkg::dispatch_packet_t packet;

	fetch_queue_if fq ();

	assign update = '{
		valid:     update_valid,
		is_branch: update_is_branch,
		taken:     update_taken,
		pc:        update_pc,
		target:    update_target
	};

	fetch_stage i_fetch (
		.clock        (clock),
		.reset        (reset),
		.icache_data  (icache_data),
		.icache_valid (icache_valid),
		.squash       (squash),
		.squash_pc    (squash_pc),
		.update       (update),
		.imem_addr    (imem_addr),
		.fq           (fq.producer)
	);

	dispatch_queue #(
		.payload_t (frontend_pkg::fetch_packet_t)
	) i_queue (
		.clock (clock),
		.reset (reset),
		.fq    (fq.buffer)
	);

	decode_stage i_decode (
		.clock          (clock),
		.reset          (reset),
		.squash         (squash),
		.dispatch_stall (dispatch_stall),
		.fq             (fq.consumer),
		.packet         (packet),
		.dispatch_valid (dispatch_valid)
	);

	// flatten the packet onto ports
	assign dispatch_pc            = packet.pc;
	assign dispatch_npc           = packet.npc;
	assign dispatch_npc_pred      = packet.npc_pred;
	assign dispatch_inst          = packet.inst;
	assign dispatch_op_class      = packet.op_class;
	assign dispatch_dest_reg_idx  = packet.dest_reg_idx;
	assign dispatch_req_reg       = packet.req_reg;
	assign dispatch_input_reg_idx = packet.input_reg_idx;
	assign dispatch_rd_mem        = packet.rd_mem;
	assign dispatch_wr_mem        = packet.wr_mem;
	assign dispatch_cond_branch   = packet.cond_branch;
	assign dispatch_uncond_branch = packet.uncond_branch;
	assign dispatch_take_branch   = packet.take_branch;
	assign dispatch_illegal       = packet.illegal;
endmodule

// ==== decode_stage.sv ====
/*
 * RV32I decode of the queue head into a registered dispatch packet
 * pops whenever the queue has an entry and dispatch_stall is low
 * outputs hold under stall, squash drops dispatch_valid
 * unknown opcodes flag illegal and write no register
 */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module decode_stage (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           squash,
	input  logic                           dispatch_stall,
	fetch_queue_if.consumer                fq,
	output frontend_pkg::dispatch_packet_t packet,
	output logic                           dispatch_valid
);
	frontend_pkg::fetch_packet_t    head;
	frontend_pkg::dispatch_packet_t dec;
	frontend_pkg::dest_sel_e        dest_sel;
	logic                           pop;
	logic [6:0]                     opcode;

	assign head   = fq.read_data;
	assign opcode = head.inst[6:0];
	assign pop    = !fq.empty && !dispatch_stall;

	assign fq.read_en = pop;

	//////////////////////////////////////////////////////////////////////
	// combinational decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		dec                  = '0;
		dec.pc               = head.pc;
		dec.npc              = head.pc + 32'd4;
		dec.npc_pred         = head.npc_pred;
		dec.inst             = head.inst;
		dec.take_branch      = head.take_branch;
		dec.op_class         = frontend_pkg::ALU;
		dest_sel             = frontend_pkg::DEST_RD;
		// rs1 needed unless told otherwise, rs2 only on request
		dec.req_reg          = 2'b01;

		case (opcode)
			`RV32_OP_LUI, `RV32_OP_AUIPC: begin
				dec.op_class = frontend_pkg::UPPER;
				dec.req_reg  = 2'b00;
			end
			`RV32_OP_JAL: begin
				dec.op_class      = frontend_pkg::JUMP;
				dec.uncond_branch = 1'b1;
				dec.req_reg       = 2'b00;
			end
			`RV32_OP_JALR: begin
				dec.op_class      = frontend_pkg::JUMP;
				dec.uncond_branch = 1'b1;
			end
			`RV32_OP_BRANCH: begin
				dec.op_class    = frontend_pkg::BRANCH;
				dec.cond_branch = 1'b1;
				dec.req_reg     = 2'b11;
				dest_sel        = frontend_pkg::DEST_NONE;
			end
			`RV32_OP_LOAD: begin
				dec.op_class = frontend_pkg::LOAD;
				dec.rd_mem   = 1'b1;
			end
			`RV32_OP_STORE: begin
				dec.op_class = frontend_pkg::STORE;
				dec.wr_mem   = 1'b1;
				dec.req_reg  = 2'b11;
				dest_sel     = frontend_pkg::DEST_NONE;
			end
			`RV32_OP_IMM: begin
				dec.op_class = frontend_pkg::ALU;
			end
			`RV32_OP_REG: begin
				dec.req_reg = 2'b11;
			end
			default: begin
				dec.illegal = 1'b1;
				dest_sel    = frontend_pkg::DEST_NONE;
			end
		endcase

		// rd at [11:7], rs1 at [19:15], rs2 at [24:20]
		dec.dest_reg_idx = (dest_sel == frontend_pkg::DEST_RD) ? head.inst[11:7] : `ZERO_REG;
		dec.input_reg_idx[0] = dec.req_reg[0] ? head.inst[19:15] : 5'd0;
		dec.input_reg_idx[1] = dec.req_reg[1] ? head.inst[24:20] : 5'd0;
	end

	//////////////////////////////////////////////////////////////////////
	// dispatch register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || squash) begin
			dispatch_valid <= 1'b0;
		end else if (!dispatch_stall) begin
			// drops when the queue ran dry
			dispatch_valid <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			packet <= dec;
		end
	end
endmodule

// ==== dispatch_queue.sv ====
/*
 * circular FIFO between fetch and decode, FQ_DEPTH entries
 * write and read in the same cycle are fine, flush empties it
 * read_data is the head entry, undefined while empty
 */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module dispatch_queue #(
	parameter type payload_t = frontend_pkg::fetch_packet_t
) (
	input logic           clock,
	input logic           reset,
	fetch_queue_if.buffer fq
);
	localparam int PTR_W = $clog2(`FQ_DEPTH);
	localparam int CNT_W = $clog2(`FQ_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`FQ_DEPTH - 1);

	// entry storage
	payload_t         mem [`FQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_write;
	logic             do_read;

	assign fq.full      = (count == CNT_W'(`FQ_DEPTH));
	assign fq.empty     = (count == '0);
	assign fq.read_data = mem[rd_ptr];

	// guard against protocol slips
	assign do_write = fq.write_en && !fq.full;
	assign do_read  = fq.read_en && !fq.empty;

	//////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || fq.flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			// both at once leaves count alone
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// data array, no reset
	always_ff @(posedge clock) begin
		if (do_write) begin
			mem[wr_ptr] <= fq.write_data;
		end
	end
endmodule

// ==== fetch_stage.sv ====
/*
 * fetch: PC register, 32-bit select out of the 64-bit cache word
 * cache answers in the same cycle, write only when valid, not full, no squash
 * squash has priority over the predicted next PC
 */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module fetch_stage (
	input  logic                         clock,
	input  logic                         reset,
	input  logic [63:0]                  icache_data,
	input  logic                         icache_valid,
	input  logic                         squash,
	input  logic [`XLEN-1:0]             squash_pc,
	input  frontend_pkg::branch_update_t update,
	output logic [`XLEN-1:0]             imem_addr,
	fetch_queue_if.producer              fq
);
	logic [`XLEN-1:0] pc_reg;
	logic [31:0]      inst;
	logic [`XLEN-1:0] npc_pred;
	logic             take_branch;
	logic             fetch_write;

	// cache is addressed by 8-byte word
	assign imem_addr = {pc_reg[`XLEN-1:3], 3'b000};

	// pc bit 2 picks the upper instruction
	assign inst = pc_reg[2] ? icache_data[63:32] : icache_data[31:0];

	assign fetch_write = icache_valid && !fq.full && !squash;

	next_pc_predictor i_predictor (
		.clock       (clock),
		.reset       (reset),
		.squash      (squash),
		.pc          (pc_reg),
		.inst        (inst),
		.update      (update),
		.push_pop_en (fetch_write),
		.npc_pred    (npc_pred),
		.take_branch (take_branch)
	);

	//////////////////////////////////////////////////////////////////////
	// queue side
	//////////////////////////////////////////////////////////////////////
	assign fq.write_en   = fetch_write;
	assign fq.flush      = squash;
	assign fq.write_data = '{
		pc:          pc_reg,
		inst:        inst,
		npc_pred:    npc_pred,
		take_branch: take_branch
	};

	// pc only moves on a redirect or an accepted fetch
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0;
		end else if (squash) begin
			pc_reg <= squash_pc;
		end else if (fetch_write) begin
			pc_reg <= npc_pred;
		end
	end
endmodule

// ==== next_pc_predictor.sv ====
/*
 * next PC prediction: direct-mapped BTB with 2-bit counters plus a RAS
 * only conditional branches use the BTB, JAL pushes and JALR pops the RAS
 * RAS overflow overwrites the oldest entry, squash empties the stack
 */
`timescale 1ns/100ps
`include "frontend_macros.svh"

module next_pc_predictor (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         squash,
	input  logic [`XLEN-1:0]             pc,
	input  logic [`XLEN-1:0]             inst,
	input  frontend_pkg::branch_update_t update,
	input  logic                         push_pop_en,
	output logic [`XLEN-1:0]             npc_pred,
	output logic                         take_branch
);
	localparam int IDX_W     = $clog2(`BTB_ENTRIES);
	localparam int TAG_W     = `XLEN - IDX_W - 2;
	localparam int RAS_PTR_W = $clog2(`RAS_DEPTH);
	localparam int RAS_CNT_W = $clog2(`RAS_DEPTH + 1);

	// btb arrays
	logic                 btb_valid  [`BTB_ENTRIES];
	logic [TAG_W-1:0]     btb_tag    [`BTB_ENTRIES];
	logic [`XLEN-1:0]     btb_target [`BTB_ENTRIES];
	logic [1:0]           btb_ctr    [`BTB_ENTRIES];

	// ras storage, top is one below ras_top
	logic [`XLEN-1:0]     ras_mem [`RAS_DEPTH];
	logic [RAS_PTR_W-1:0] ras_top;
	logic [RAS_PTR_W-1:0] ras_top_m1;
	logic [RAS_CNT_W-1:0] ras_count;

	logic [IDX_W-1:0]     rd_idx, up_idx;
	logic [TAG_W-1:0]     rd_tag, up_tag;
	logic                 rd_hit, up_hit;
	logic [`XLEN-1:0]     pc_plus_4;
	logic [6:0]           opcode;
	logic                 is_cond, is_jal, is_jalr;

	//////////////////////////////////////////////////////////////////////
	// lookup and predecode
	//////////////////////////////////////////////////////////////////////
	assign rd_idx     = pc[IDX_W+1:2];
	assign rd_tag     = pc[`XLEN-1:IDX_W+2];
	assign up_idx     = update.pc[IDX_W+1:2];
	assign up_tag     = update.pc[`XLEN-1:IDX_W+2];
	assign rd_hit     = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
	assign up_hit     = btb_valid[up_idx] && (btb_tag[up_idx] == up_tag);

	assign pc_plus_4  = pc + 32'd4;
	assign opcode     = inst[6:0];
	assign is_cond    = (opcode == `RV32_OP_BRANCH);
	assign is_jal     = (opcode == `RV32_OP_JAL);
	assign is_jalr    = (opcode == `RV32_OP_JALR);
	assign ras_top_m1 = ras_top - 1'b1;

	// counter msb set means weakly or strongly taken
	assign take_branch = is_cond && rd_hit && btb_ctr[rd_idx][1];

	// return prediction wins, then btb, then fall-through
	assign npc_pred = (is_jalr && ras_count != '0) ? ras_mem[ras_top_m1] :
	                  take_branch                   ? btb_target[rd_idx] :
	                                                  pc_plus_4;

	//////////////////////////////////////////////////////////////////////
	// btb training
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `BTB_ENTRIES; i++) begin
				btb_valid[i] <= 1'b0;
			end
		end else if (update.valid && update.is_branch) begin
			btb_valid[up_idx]  <= 1'b1;
			btb_tag[up_idx]    <= up_tag;
			btb_target[up_idx] <= update.target;
			if (!up_hit) begin
				// fresh entry starts weak
				btb_ctr[up_idx] <= update.taken ? 2'd2 : 2'd1;
			end else if (update.taken && btb_ctr[up_idx] != 2'd3) begin
				btb_ctr[up_idx] <= btb_ctr[up_idx] + 2'd1;
			end else if (!update.taken && btb_ctr[up_idx] != 2'd0) begin
				btb_ctr[up_idx] <= btb_ctr[up_idx] - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// return address stack
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || squash) begin
			ras_top   <= '0;
			ras_count <= '0;
		end else if (push_pop_en && is_jal) begin
			ras_mem[ras_top] <= pc_plus_4;
			ras_top          <= ras_top + 1'b1;
			// saturate, oldest entry is lost
			if (ras_count != RAS_CNT_W'(`RAS_DEPTH)) begin
				ras_count <= ras_count + 1'b1;
			end
		end else if (push_pop_en && is_jalr && ras_count != '0) begin
			ras_top   <= ras_top_m1;
			ras_count <= ras_count - 1'b1;
		end
	end
endmodule

// ==== fetch_queue_if.sv ====
/*
 * fetch -> queue -> decode signals
 * strobes are single-cycle levels sampled at the rising edge, no handshake
 * writer must hold off while full, reader while empty
 */
`timescale 1ns/100ps

interface fetch_queue_if #(
	parameter type payload_t = frontend_pkg::fetch_packet_t
);
	// fetch side
	logic     write_en;
	payload_t write_data;
	logic     full;
	// decode side
	logic     read_en;
	payload_t read_data;
	logic     empty;
	// squash copy from fetch
	logic     flush;

	modport producer (
		output write_en, write_data, flush,
		input  full
	);

	modport buffer (
		input  write_en, write_data, read_en, flush,
		output full, read_data, empty
	);

	modport consumer (
		output read_en,
		input  read_data, empty
	);
endinterface

// ==== frontend_pkg.sv ====
/*
 * packet and enum types shared by fetch, queue and decode
 * fetch_packet_t is the fetch queue payload, 97 bits wide
 */
`include "frontend_macros.svh"

package frontend_pkg;

	// coarse class used to steer dispatch
	typedef enum logic [2:0] {
		ALU    = 3'd0,
		LOAD   = 3'd1,
		STORE  = 3'd2,
		BRANCH = 3'd3,
		JUMP   = 3'd4,
		UPPER  = 3'd5
	} op_class_e;

	// which field feeds dest_reg_idx
	typedef enum logic {
		DEST_RD   = 1'b0,
		DEST_NONE = 1'b1
	} dest_sel_e;

	// one fetched instruction plus its prediction
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0]      inst;
		logic [`XLEN-1:0] npc_pred;
		logic             take_branch;
	} fetch_packet_t;

	//////////////////////////////////////////////////////////////////////
	// decoded packet handed to dispatch
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  npc;
		logic [`XLEN-1:0]  npc_pred;
		logic [31:0]       inst;
		op_class_e         op_class;
		logic [4:0]        dest_reg_idx;
		// [0] rs1, [1] rs2
		logic [1:0]        req_reg;
		logic [1:0][4:0]   input_reg_idx;
		logic              rd_mem;
		logic              wr_mem;
		logic              cond_branch;
		logic              uncond_branch;
		logic              take_branch;
		logic              illegal;
	} dispatch_packet_t;

	// resolved branch from the back end, trains the BTB
	typedef struct packed {
		logic             valid;
		logic             is_branch;
		logic             taken;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] target;
	} branch_update_t;

endpackage

// ==== frontend_macros.svh ====
/*
 * shared sizes and RV32 opcodes for the front end
 * FQ_DEPTH, BTB_ENTRIES and RAS_DEPTH must be powers of two
 */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// datapath width
`define XLEN 32

// fetch queue entries
`define FQ_DEPTH 4

// direct-mapped BTB sets
`define BTB_ENTRIES 16

// return address stack entries
`define RAS_DEPTH 4

//////////////////////////////////////////////////////////////////////
// RV32I major opcodes, inst[6:0]
//////////////////////////////////////////////////////////////////////
`define RV32_OP_LUI    7'b0110111
`define RV32_OP_AUIPC  7'b0010111
`define RV32_OP_JAL    7'b1101111
`define RV32_OP_JALR   7'b1100111
`define RV32_OP_BRANCH 7'b1100011
`define RV32_OP_LOAD   7'b0000011
`define RV32_OP_STORE  7'b0100011
`define RV32_OP_IMM    7'b0010011
`define RV32_OP_REG    7'b0110011

// x0 stands in for "no destination"
`define ZERO_REG 5'd0

`endif
